// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= z8CoreTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/z8CorePkg.sv ====
`default_nettype none

package z8CorePkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] addrT;
    typedef logic [7:0]  regAddrT;

    typedef enum logic [3:0] {
        fetchInstr,
        readInstr,
        wait2,
        read2,
        wait3,
        read3,
        decode,
        aluExec,
        djnzExec,
        djnzBranch,
        ldcReadStrobe,
        ldcReadCapture,
        ldcWriteStrobe
    } seqStateT;

    // First instruction address
    localparam addrT RESET_PC = 16'h000C;

endpackage

`default_nettype wire

// ==== common/z8IsaPkg.sv ====
`default_nettype none

package z8IsaPkg;

    // ALU operations, two-operand codes follow the opcode high nibble
    typedef enum logic [4:0] {
        aluAdd             = 5'h00,
        aluAdc             = 5'h01,
        aluSub             = 5'h02,
        aluSbc             = 5'h03,
        aluOr              = 5'h04,
        aluAnd             = 5'h05,
        aluTcm             = 5'h06,
        aluTm              = 5'h07,
        aluCp              = 5'h0A,
        aluXor             = 5'h0B,
        aluLd              = 5'h10,
        aluInc             = 5'h11,
        aluDec             = 5'h12,
        aluSetCarry        = 5'h13,
        aluClearCarry      = 5'h14,
        aluComplementCarry = 5'h15
    } aluModeT;

    // Flag bit positions within the flags byte
    localparam int FLAG_C = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_S = 5;
    localparam int FLAG_V = 4;

    // Special registers
    localparam logic [7:0] REG_FLAGS = 8'hFC;
    localparam logic [7:0] REG_RP    = 8'hFD;

    // High nibble marking a working register
    localparam logic [3:0] WORK_PREFIX = 4'hE;

    // Opcode low nibbles
    localparam logic [3:0] LO_ALU_RR = 4'h2;
    localparam logic [3:0] LO_ALU_IM = 4'h6;
    localparam logic [3:0] LO_DJNZ   = 4'hA;
    localparam logic [3:0] LO_JR     = 4'hB;
    localparam logic [3:0] LO_LD_IMM = 4'hC;
    localparam logic [3:0] LO_JP     = 4'hD;
    localparam logic [3:0] LO_INC    = 4'hE;

    // Full opcodes
    localparam logic [7:0] OP_SRP       = 8'h31;
    localparam logic [7:0] OP_LDC_READ  = 8'hC2;
    localparam logic [7:0] OP_LDC_WRITE = 8'hD2;
    localparam logic [7:0] OP_RCF       = 8'hCF;
    localparam logic [7:0] OP_SCF       = 8'hDF;
    localparam logic [7:0] OP_CCF       = 8'hEF;
    localparam logic [7:0] OP_NOP       = 8'hFF;

endpackage

`default_nettype wire

// ==== sequencer/z8Sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module z8Sequencer (
    input  logic               clk,
    input  logic               arstN,
    output z8CorePkg::addrT    memAddr,
    output logic               memStrobe,
    output logic               memWrite,
    output z8CorePkg::byteT    memDataWrite,
    input  z8CorePkg::byteT    memDataRead,
    output z8CorePkg::regAddrT rdAddrA,
    output z8CorePkg::regAddrT rdAddrB,
    input  z8CorePkg::byteT    rdDataA,
    input  z8CorePkg::byteT    rdDataB,
    output logic               regWrEn,
    output z8CorePkg::regAddrT regWrAddr,
    output logic               flagsWrEn,
    output z8IsaPkg::aluModeT  aluMode,
    output z8CorePkg::byteT    aluA,
    output z8CorePkg::byteT    aluB,
    input  z8CorePkg::byteT    aluResult,
    input  z8CorePkg::byteT    aluFlags,
    input  z8CorePkg::byteT    flags
);
    import z8IsaPkg::*;
    import z8CorePkg::*;

    seqStateT   state;
    addrT       pc;
    byteT       instr;
    byteT       second;
    byteT       third;
    addrT       ldcAddr;
    addrT       relTarget;
    logic [3:0] instrH;
    logic [3:0] instrL;
    logic       isAluOp;
    logic       writesDest;
    logic       isInc;
    logic       isDjnz;
    logic       isLdImm;
    logic       isSrp;
    logic       isCarryOp;
    logic       isLdcRead;
    logic       isLdcWrite;
    logic       takeBranch;

    function automatic logic isSize1(byteT op);
        return op[3:1] == 3'b111;
    endfunction

    function automatic logic isSize3(byteT op);
        return op[3:2] == 2'b01 || op[3:0] == LO_JP;
    endfunction

    function automatic logic condMet(logic [3:0] cc, byteT f);
        logic base;
        case (cc[2:0])
            3'd0: base = 1'b0;
            3'd1: base = f[FLAG_S] ^ f[FLAG_V];
            3'd2: base = (f[FLAG_S] ^ f[FLAG_V]) | f[FLAG_Z];
            3'd3: base = f[FLAG_C] | f[FLAG_Z];
            3'd4: base = f[FLAG_V];
            3'd5: base = f[FLAG_S];
            3'd6: base = f[FLAG_Z];
            default: base = f[FLAG_C];
        endcase
        // Upper half of the codes is the inverse condition
        return base ^ cc[3];
    endfunction

    assign instrH = instr[7:4];
    assign instrL = instr[3:0];

    assign isAluOp = (instrL == LO_ALU_RR || instrL == LO_ALU_IM)
                   && (instrH[3] == 1'b0 || instrH[3:1] == 3'b101);
    // tcm, tm and cp only touch the flags
    assign writesDest = instrH[3:2] == 2'b00 || instrH[3:1] == 3'b010 || instrH == 4'hB;
    assign isInc      = instrL == LO_INC;
    assign isDjnz     = instrL == LO_DJNZ;
    assign isLdImm    = instrL == LO_LD_IMM;
    assign isSrp      = instr == OP_SRP;
    assign isCarryOp  = instr == OP_SCF || instr == OP_RCF || instr == OP_CCF;
    assign isLdcRead  = instr == OP_LDC_READ;
    assign isLdcWrite = instr == OP_LDC_WRITE;
    assign takeBranch = condMet(instrH, flags);
    assign relTarget  = pc + {{8{second[7]}}, second};

    always_comb begin
        rdAddrA = {WORK_PREFIX, second[7:4]};
        rdAddrB = {WORK_PREFIX, second[3:0]};
        if (state == decode) begin
            if (isLdcRead || isLdcWrite) begin
                // Address pair, high byte at the even register
                rdAddrA = {WORK_PREFIX, second[3:1], 1'b0};
                rdAddrB = {WORK_PREFIX, second[3:1], 1'b1};
            end else if (instrL == LO_ALU_IM) begin
                rdAddrA = second;
            end else if (isDjnz || isInc) begin
                rdAddrA = {WORK_PREFIX, instrH};
            end
        end
    end

    assign memStrobe = state == fetchInstr || state == wait2 || state == wait3
                     || state == ldcReadStrobe || state == ldcWriteStrobe;
    assign memWrite = state == ldcWriteStrobe;
    assign memAddr = (state == ldcReadStrobe || state == ldcWriteStrobe) ? ldcAddr : pc;
    // Source register is on port A while the write strobe is out
    assign memDataWrite = rdDataA;

    // Reset parks in decode on a nop so the bus stays idle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= decode;
            pc        <= RESET_PC;
            instr     <= OP_NOP;
            regWrEn   <= 1'b0;
            flagsWrEn <= 1'b0;
        end else begin
            regWrEn   <= 1'b0;
            flagsWrEn <= 1'b0;
            case (state)
                fetchInstr: state <= readInstr;
                readInstr: begin
                    instr <= memDataRead;
                    pc    <= pc + 16'd1;
                    state <= isSize1(memDataRead) ? decode : wait2;
                end
                wait2: state <= read2;
                read2: begin
                    pc    <= pc + 16'd1;
                    state <= isSize3(instr) ? wait3 : decode;
                end
                wait3: state <= read3;
                read3: begin
                    pc    <= pc + 16'd1;
                    state <= decode;
                end
                decode: begin
                    state <= fetchInstr;
                    if (isAluOp) begin
                        regWrEn   <= writesDest;
                        flagsWrEn <= 1'b1;
                        state     <= aluExec;
                    end else if (isInc) begin
                        regWrEn   <= 1'b1;
                        flagsWrEn <= 1'b1;
                        state     <= aluExec;
                    end else if (isLdImm || isSrp) begin
                        regWrEn <= 1'b1;
                    end else if (isCarryOp) begin
                        flagsWrEn <= 1'b1;
                    end else if (isDjnz) begin
                        state <= djnzExec;
                    end else if (isLdcRead) begin
                        state <= ldcReadStrobe;
                    end else if (isLdcWrite) begin
                        state <= ldcWriteStrobe;
                    end else if (instrL == LO_JR && takeBranch) begin
                        pc <= relTarget;
                    end else if (instrL == LO_JP && takeBranch) begin
                        pc <= {second, third};
                    end
                end
                aluExec: state <= fetchInstr;
                djnzExec: begin
                    regWrEn <= 1'b1;
                    state   <= djnzBranch;
                end
                djnzBranch: begin
                    // Loop while the decremented count is nonzero
                    if (!aluFlags[FLAG_Z]) begin
                        pc <= relTarget;
                    end
                    state <= fetchInstr;
                end
                ldcReadStrobe: state <= ldcReadCapture;
                ldcReadCapture: begin
                    regWrEn <= 1'b1;
                    state   <= fetchInstr;
                end
                default: state <= fetchInstr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            read2: second <= memDataRead;
            read3: third <= memDataRead;
            decode: begin
                aluA      <= rdDataA;
                aluB      <= rdDataB;
                regWrAddr <= {WORK_PREFIX, second[7:4]};
                if (isAluOp) begin
                    aluMode <= aluModeT'({1'b0, instrH});
                    if (instrL == LO_ALU_IM) begin
                        aluB      <= third;
                        regWrAddr <= second;
                    end
                end else if (isInc || isDjnz) begin
                    aluMode   <= isInc ? aluInc : aluDec;
                    regWrAddr <= {WORK_PREFIX, instrH};
                end else if (isLdImm) begin
                    aluMode   <= aluLd;
                    aluA      <= second;
                    regWrAddr <= {WORK_PREFIX, instrH};
                end else if (isSrp) begin
                    aluMode   <= aluLd;
                    aluA      <= second;
                    regWrAddr <= REG_RP;
                end else if (isCarryOp) begin
                    aluMode <= (instr == OP_SCF) ? aluSetCarry
                             : (instr == OP_RCF) ? aluClearCarry : aluComplementCarry;
                end else if (isLdcRead || isLdcWrite) begin
                    ldcAddr <= {rdDataA, rdDataB};
                end
            end
            ldcReadCapture: begin
                aluA    <= memDataRead;
                aluMode <= aluLd;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/z8Alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module z8Alu (
    input  z8IsaPkg::aluModeT mode,
    input  z8CorePkg::byteT   a,
    input  z8CorePkg::byteT   b,
    input  z8CorePkg::byteT   flagsIn,
    output z8CorePkg::byteT   result,
    output z8CorePkg::byteT   flagsOut
);
    import z8IsaPkg::*;

    logic [8:0] wide;
    logic       carryIn;
    logic       updateZs;
    logic       carryOp;

    assign carryIn = flagsIn[FLAG_C] & (mode == aluAdc || mode == aluSbc);

    always_comb begin
        wide     = 9'd0;
        result   = a;
        flagsOut = flagsIn;
        updateZs = 1'b1;
        carryOp  = 1'b0;
        case (mode)
            aluAdd, aluAdc: begin
                wide             = {1'b0, a} + {1'b0, b} + {8'd0, carryIn};
                result           = wide[7:0];
                flagsOut[FLAG_C] = wide[8];
                flagsOut[FLAG_V] = (a[7] == b[7]) && (result[7] != a[7]);
            end
            aluSub, aluSbc, aluCp: begin
                // Bit 8 is the borrow
                wide             = {1'b0, a} - {1'b0, b} - {8'd0, carryIn};
                result           = wide[7:0];
                flagsOut[FLAG_C] = wide[8];
                flagsOut[FLAG_V] = (a[7] != b[7]) && (result[7] != a[7]);
            end
            aluOr: begin
                result           = a | b;
                flagsOut[FLAG_V] = 1'b0;
            end
            aluAnd, aluTm: begin
                result           = a & b;
                flagsOut[FLAG_V] = 1'b0;
            end
            aluTcm: begin
                result           = ~a & b;
                flagsOut[FLAG_V] = 1'b0;
            end
            aluXor: begin
                result           = a ^ b;
                flagsOut[FLAG_V] = 1'b0;
            end
            aluInc: begin
                result           = a + 8'd1;
                flagsOut[FLAG_V] = result == 8'h80;
            end
            aluDec: begin
                result           = a - 8'd1;
                flagsOut[FLAG_V] = result == 8'h7F;
            end
            aluSetCarry: begin
                flagsOut[FLAG_C] = 1'b1;
                updateZs         = 1'b0;
                carryOp          = 1'b1;
            end
            aluClearCarry: begin
                flagsOut[FLAG_C] = 1'b0;
                updateZs         = 1'b0;
                carryOp          = 1'b1;
            end
            aluComplementCarry: begin
                flagsOut[FLAG_C] = ~flagsIn[FLAG_C];
                updateZs         = 1'b0;
                carryOp          = 1'b1;
            end
            aluLd: updateZs = 1'b0;
            default: updateZs = 1'b0;
        endcase
        if (updateZs) begin
            flagsOut[FLAG_Z] = result == 8'h00;
            flagsOut[FLAG_S] = result[7];
        end
        // Carry ops are written back as the whole flags byte
        if (carryOp) begin
            result = flagsOut;
        end
    end

endmodule

`default_nettype wire

// ==== source/z8Core.sv ====
`timescale 1ns/1ps
`default_nettype none

module z8Core (
    input  logic            clk,
    input  logic            arstN,
    output z8CorePkg::addrT memAddr,
    output logic            memStrobe,
    output logic            memWrite,
    output z8CorePkg::byteT memDataWrite,
    input  z8CorePkg::byteT memDataRead
);
    import z8IsaPkg::*;
    import z8CorePkg::*;

    regAddrT rdAddrA;
    regAddrT rdAddrB;
    regAddrT regWrAddr;
    byteT    rdDataA;
    byteT    rdDataB;
    byteT    aluA;
    byteT    aluB;
    byteT    aluResult;
    byteT    aluFlags;
    byteT    flags;
    logic    regWrEn;
    logic    flagsWrEn;
    aluModeT aluMode;

    z8Sequencer sequencer (
        .clk(clk),
        .arstN(arstN),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .memWrite(memWrite),
        .memDataWrite(memDataWrite),
        .memDataRead(memDataRead),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .regWrEn(regWrEn),
        .regWrAddr(regWrAddr),
        .flagsWrEn(flagsWrEn),
        .aluMode(aluMode),
        .aluA(aluA),
        .aluB(aluB),
        .aluResult(aluResult),
        .aluFlags(aluFlags),
        .flags(flags)
    );

    z8Alu alu (
        .mode(aluMode),
        .a(aluA),
        .b(aluB),
        .flagsIn(flags),
        .result(aluResult),
        .flagsOut(aluFlags)
    );

    // Register writes always take the ALU result
    z8RegisterFile registerFile (
        .clk(clk),
        .arstN(arstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn(regWrEn),
        .wrAddr(regWrAddr),
        .wrData(aluResult),
        .flagsWrEn(flagsWrEn),
        .flagsIn(aluFlags),
        .flags(flags)
    );

endmodule

`default_nettype wire

// ==== source/z8RegisterFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module z8RegisterFile (
    input  logic               clk,
    input  logic               arstN,
    input  z8CorePkg::regAddrT rdAddrA,
    input  z8CorePkg::regAddrT rdAddrB,
    output z8CorePkg::byteT    rdDataA,
    output z8CorePkg::byteT    rdDataB,
    input  logic               wrEn,
    input  z8CorePkg::regAddrT wrAddr,
    input  z8CorePkg::byteT    wrData,
    input  logic               flagsWrEn,
    input  z8CorePkg::byteT    flagsIn,
    output z8CorePkg::byteT    flags
);
    import z8IsaPkg::*;
    import z8CorePkg::*;

    byteT       regs [0:127];
    logic [3:0] rp;
    regAddrT    wrTarget;

    // Working register r0..r15 lives at rp:n
    function automatic regAddrT expand(regAddrT addr);
        if (addr[7:4] == WORK_PREFIX) begin
            return {rp, addr[3:0]};
        end
        return addr;
    endfunction

    function automatic byteT readReg(regAddrT addr);
        byteT value;
        if (addr[7] == 1'b0) begin
            value = regs[addr[6:0]];
        end else if (addr == REG_FLAGS) begin
            value = flags;
        end else if (addr == REG_RP) begin
            value = {rp, 4'h0};
        end else begin
            value = 8'h00;
        end
        return value;
    endfunction

    always_comb begin
        rdDataA  = readReg(expand(rdAddrA));
        rdDataB  = readReg(expand(rdAddrB));
        wrTarget = expand(wrAddr);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 128; i++) begin
                regs[i] <= 8'h00;
            end
            rp    <= 4'h0;
            flags <= 8'h00;
        end else begin
            if (wrEn && wrTarget[7] == 1'b0) begin
                regs[wrTarget[6:0]] <= wrData;
            end
            if (wrEn && wrTarget == REG_RP) begin
                rp <= wrData[7:4];
            end
            // Explicit write to the flags register wins over the ALU flags
            if (wrEn && wrTarget == REG_FLAGS) begin
                flags <= wrData;
            end else if (flagsWrEn) begin
                flags <= flagsIn;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/memPort_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module memPortChecker (
    input wire logic        clk,
    input wire logic        arstN,
    input wire logic [15:0] memAddr,
    input wire logic        memStrobe,
    input wire logic        memWrite
);

    // A write is always a strobed cycle
    writeHasStrobe: assert property (
        @(posedge clk) disable iff (!arstN) memWrite |-> memStrobe
    ) else $error("memWrite high without memStrobe");

    quietInReset: assert property (
        @(posedge clk) !arstN |-> !memStrobe
    ) else $error("memStrobe high during reset");

    addrKnown: assert property (
        @(posedge clk) disable iff (!arstN) memStrobe |-> !$isunknown(memAddr)
    ) else $error("memAddr has unknown bits during a strobe");

endmodule

bind z8Core memPortChecker portCheck (
    .clk(clk),
    .arstN(arstN),
    .memAddr(memAddr),
    .memStrobe(memStrobe),
    .memWrite(memWrite)
);

`default_nettype wire

// ==== tb/z8CoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module z8CoreTb;
    logic        clk;
    logic        arstN;
    logic [15:0] memAddr;
    logic        memStrobe;
    logic        memWrite;
    logic [7:0]  memDataWrite;
    logic [7:0]  memDataRead;

    logic [7:0]  mem [0:65535];
    logic [7:0]  dataM [0:255];
    logic [7:0]  regsM [0:127];
    logic [3:0]  rpM;
    logic [7:0]  flagsM;
    logic [15:0] expReads [$];
    logic [15:0] expWrAddr [$];
    logic [7:0]  expWrData [$];
    logic [15:0] wp;
    logic [15:0] pendAddr;
    logic        pendRead;
    logic        done;
    int          seed;
    int          steps;
    int          cycles;
    int          limit;
    int          valueErrors;
    int          otherErrors;

    z8Core u_dut (
        .clk(clk),
        .arstN(arstN),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .memWrite(memWrite),
        .memDataWrite(memDataWrite),
        .memDataRead(memDataRead)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [7:0] randBelow(input logic [7:0] n);
        int r;
        r = $random(seed);
        return 8'($unsigned(r) % {24'd0, n});
    endfunction

    task automatic emit(input logic [7:0] b);
        mem[wp] = b;
        wp = wp + 16'd1;
    endtask

    // Point r14 and r15 at a random byte in the data window
    task automatic emitPairLoad();
        emit(8'hEC);
        emit(8'h80);
        emit(8'hFC);
        emit(randBelow(8'd255));
    endtask

    task automatic emitLdcWrite();
        emit(8'hD2);
        emit({4'(randBelow(8'd12)), 4'hE});
    endtask

    task automatic genProgram();
        logic [3:0]  aluOps [0:9];
        logic [3:0]  d;
        logic [15:0] target;
        aluOps = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hA, 4'hB};
        wp = 16'h000C;
        for (int i = 0; i < 200; i++) begin
            d = 4'(randBelow(8'd12));
            case (randBelow(8'd11))
                8'd0: begin
                    emit({aluOps[randBelow(8'd10)], 4'h2});
                    emit({d, 4'(randBelow(8'd12))});
                end
                8'd1: begin
                    emit({aluOps[randBelow(8'd10)], 4'h6});
                    emit({4'hE, d});
                    emit(randBelow(8'd255));
                end
                8'd2: begin
                    emit({d, 4'hC});
                    emit(randBelow(8'd255));
                end
                8'd3: emit({d, 4'hE});
                8'd4: emit({4'(randBelow(8'd4)) + 4'hC, 4'hF});
                8'd5: begin
                    emit(8'h31);
                    emit({4'(randBelow(8'd8)), 4'h0});
                end
                8'd6: begin
                    emitPairLoad();
                    emitLdcWrite();
                end
                8'd7: begin
                    emitPairLoad();
                    emit(8'hC2);
                    emit({d, 4'hE});
                    emit(8'hD2);
                    emit({d, 4'hE});
                end
                8'd8: begin
                    emit({4'(randBelow(8'd16)), 4'hB});
                    emit(8'd6);
                    emitPairLoad();
                    emitLdcWrite();
                end
                8'd9: begin
                    target = wp + 16'd9;
                    emit({4'(randBelow(8'd16)), 4'hD});
                    emit(target[15:8]);
                    emit(target[7:0]);
                    emitPairLoad();
                    emitLdcWrite();
                end
                default: begin
                    // Loop body of inc, ldc write and djnz sits 5 bytes back
                    emitPairLoad();
                    emit(8'hDC);
                    emit(randBelow(8'd4) + 8'd1);
                    emit({d, 4'hE});
                    emit(8'hD2);
                    emit({d, 4'hE});
                    emit(8'hDA);
                    emit(8'hFB);
                end
            endcase
        end
        emit(8'h8B);
        emit(8'hFE);
    endtask

    function automatic logic [7:0] regRd(input logic [3:0] n);
        return regsM[{rpM[2:0], n}];
    endfunction

    function automatic logic condTrue(input logic [3:0] cc, input logic [7:0] f);
        logic c;
        logic z;
        logic s;
        logic v;
        c = f[7];
        z = f[6];
        s = f[5];
        v = f[4];
        case (cc)
            4'h0: return 1'b0;
            4'h1: return s ^ v;
            4'h2: return z | (s ^ v);
            4'h3: return c | z;
            4'h4: return v;
            4'h5: return s;
            4'h6: return z;
            4'h7: return c;
            4'h8: return 1'b1;
            4'h9: return !(s ^ v);
            4'hA: return !(z | (s ^ v));
            4'hB: return !(c | z);
            4'hC: return !v;
            4'hD: return !s;
            4'hE: return !z;
            default: return !c;
        endcase
    endfunction

    task automatic aluModel(input logic [3:0] op, input logic [7:0] a, input logic [7:0] b,
                            output logic [7:0] res, output logic wr);
        int cinV;
        int uv;
        int sv;
        cinV = (op == 4'h1 || op == 4'h3) ? int'(flagsM[7]) : 0;
        wr = 1'b1;
        res = 8'h00;
        case (op)
            4'h0, 4'h1: begin
                uv = int'(a) + int'(b) + cinV;
                sv = int'($signed(a)) + int'($signed(b)) + cinV;
                res = 8'(uv);
                flagsM[7] = uv > 255;
                flagsM[4] = sv > 127 || sv < -128;
            end
            4'h2, 4'h3, 4'hA: begin
                // Carry is the borrow out of the subtraction
                uv = int'(a) - int'(b) - cinV;
                sv = int'($signed(a)) - int'($signed(b)) - cinV;
                res = 8'(uv);
                flagsM[7] = uv < 0;
                flagsM[4] = sv > 127 || sv < -128;
                wr = op != 4'hA;
            end
            4'h4: res = a | b;
            4'h5, 4'h7: begin
                res = a & b;
                wr = op == 4'h5;
            end
            4'h6: begin
                res = ~a & b;
                wr = 1'b0;
            end
            default: res = a ^ b;
        endcase
        if (op >= 4'h4 && op != 4'hA) flagsM[4] = 1'b0;
        flagsM[6] = res == 8'h00;
        flagsM[5] = res[7];
    endtask

    // Instruction-level execution of the program in mem
    task automatic runModel();
        logic [15:0] pc;
        logic [15:0] addr;
        logic [7:0]  op;
        logic [7:0]  b2;
        logic [7:0]  b3;
        logic [7:0]  res;
        logic [3:0]  lo;
        logic [3:0]  hi;
        logic        wr;
        int          sz;
        pc = 16'h000C;
        rpM = 4'h0;
        flagsM = 8'h00;
        for (int i = 0; i < 128; i++) regsM[i] = 8'h00;
        for (int i = 0; i < 256; i++) dataM[i] = mem[16'h8000 + i[15:0]];
        while (steps < 20000) begin
            op = mem[pc];
            b2 = mem[pc + 16'd1];
            b3 = mem[pc + 16'd2];
            lo = op[3:0];
            hi = op[7:4];
            sz = (lo == 4'hE || lo == 4'hF) ? 1 : ((lo == 4'h6 || lo == 4'hD) ? 3 : 2);
            for (int k = 0; k < sz; k++) expReads.push_back(pc + k[15:0]);
            pc = pc + sz[15:0];
            steps++;
            if (op == 8'h8B && b2 == 8'hFE) break;
            if (op == 8'hC2 || op == 8'hD2) begin
                addr = {regRd({b2[3:1], 1'b0}), regRd({b2[3:1], 1'b1})};
                if (op == 8'hC2) begin
                    expReads.push_back(addr);
                    regsM[{rpM[2:0], b2[7:4]}] = dataM[addr[7:0]];
                end else begin
                    expWrAddr.push_back(addr);
                    expWrData.push_back(regRd(b2[7:4]));
                    dataM[addr[7:0]] = regRd(b2[7:4]);
                end
            end else if ((lo == 4'h2 || lo == 4'h6)
                         && (hi <= 4'h7 || hi == 4'hA || hi == 4'hB)) begin
                if (lo == 4'h2) aluModel(hi, regRd(b2[7:4]), regRd(b2[3:0]), res, wr);
                else aluModel(hi, regRd(b2[3:0]), b3, res, wr);
                if (wr) regsM[{rpM[2:0], (lo == 4'h2) ? b2[7:4] : b2[3:0]}] = res;
            end else if (lo == 4'hC) begin
                regsM[{rpM[2:0], hi}] = b2;
            end else if (lo == 4'hE) begin
                res = regRd(hi) + 8'd1;
                flagsM[4] = regRd(hi) == 8'h7F;
                regsM[{rpM[2:0], hi}] = res;
                flagsM[6] = res == 8'h00;
                flagsM[5] = res[7];
            end else if (lo == 4'hA) begin
                res = regRd(hi) - 8'd1;
                regsM[{rpM[2:0], hi}] = res;
                if (res != 8'h00) pc = pc + {{8{b2[7]}}, b2};
            end else if (lo == 4'hB) begin
                if (condTrue(hi, flagsM)) pc = pc + {{8{b2[7]}}, b2};
            end else if (lo == 4'hD) begin
                if (condTrue(hi, flagsM)) pc = {b2, b3};
            end else if (op == 8'h31) begin
                rpM = b2[7:4];
            end else if (op == 8'hDF) begin
                flagsM[7] = 1'b1;
            end else if (op == 8'hCF) begin
                flagsM[7] = 1'b0;
            end else if (op == 8'hEF) begin
                flagsM[7] = !flagsM[7];
            end
        end
    endtask

    // Memory model with read data one cycle after the strobe
    always @(negedge clk) begin
        if (pendRead) memDataRead <= mem[pendAddr];
        pendRead = 1'b0;
        if (arstN && memStrobe) begin
            if (memWrite) begin
                if (expWrAddr.size() == 0) begin
                    otherErrors++;
                    $display("Unexpected memory write at %h", memAddr);
                end else begin
                    checkValue("memAddr", memAddr, expWrAddr.pop_front());
                    checkValue("memDataWrite", {8'h00, memDataWrite},
                               {8'h00, expWrData.pop_front()});
                end
                mem[memAddr] = memDataWrite;
            end else begin
                pendRead = 1'b1;
                pendAddr = memAddr;
                if (expReads.size() != 0) checkValue("memAddr", memAddr, expReads.pop_front());
            end
        end
        if (arstN && expReads.size() == 0) done = 1'b1;
    end

    initial begin
        arstN = 1'b1;
        memDataRead = 8'h00;
        pendRead = 1'b0;
        pendAddr = 16'h0000;
        done = 1'b0;
        seed = 11;
        steps = 0;
        cycles = 0;
        valueErrors = 0;
        otherErrors = 0;
        for (int i = 0; i < 65536; i++) mem[i] = 8'(i >> 8) ^ 8'(i);
        for (int i = 0; i < 256; i++) mem[16'h8000 + i[15:0]] = randBelow(8'd255);
        genProgram();
        runModel();
        limit = steps * 12 + 10;
        // Falling reset edge ahead of the first rising clock edge
        #1 arstN = 1'b0;
        repeat (10) @(negedge clk);
        arstN = 1'b1;
        while (!done && cycles < limit) @(negedge clk);
        if (!done) begin
            otherErrors++;
            $display("Timeout after %0d cycles, %0d fetches never seen",
                     cycles, expReads.size());
        end
        if (expWrAddr.size() != 0) begin
            otherErrors++;
            $display("%0d expected memory writes never happened", expWrAddr.size());
        end
        $display("Errors: %0d value mismatches, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/z8IsaPkg.sv
common/z8CorePkg.sv
source/z8Alu.sv
source/z8RegisterFile.sv
sequencer/z8Sequencer.sv
source/z8Core.sv
tb/memPort_checker.sv
tb/z8CoreTb.sv
